//--- list.f
+incdir+.
fv_geom_pkg.sv
fv_pkt_pkg.sv
fv_req_decode.sv
fv_bank_cntl.sv
fv_sram_bank.sv
fv_out_fifo.sv
fv_bank_top.sv
tb_fv_bank.sv

//--- run.sh
#!/bin/sh
# Build and run the feature-value bank testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timing --top-module tb_fv_bank -f list.f
./obj_dir/Vtb_fv_bank | tee sim.log

if grep -q "^TB PASSED$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- tb_fv_model.svh
// Reference memory model of the bank SRAM
// Expected stream and edge beat queues built from it
`ifndef TB_FV_MODEL_SVH
`define TB_FV_MODEL_SVH

fv_geom_pkg::line_t          model_mem [512];
fv_pkt_pkg::fv_stream_beat_t exp_sm_q [$];
fv_pkt_pkg::fv_edge_beat_t   exp_edge_q [$];

// Two values per line, odd counts round up
function automatic int line_count(input int fv_cnt);
    return (fv_cnt + 1) / 2;
endfunction

// Node id above, line below
function automatic fv_geom_pkg::addr_t line_addr(input int node, input int line);
    return fv_geom_pkg::addr_t'(node * 8 + line);
endfunction

function automatic void expect_read(input int node, input int tag, input int fv_cnt);
    fv_pkt_pkg::fv_edge_beat_t beat;
    int                        n;
    n = line_count(fv_cnt);
    for (int i = 0; i < n; i++) begin
        beat.sos    = (i == 0);
        beat.eos    = (i == n - 1);
        beat.pe_tag = tag[1:0];
        beat.data   = model_mem[line_addr(node, i)];
        exp_edge_q.push_back(beat);
    end
endfunction

// Slots 0 up to nodes-1 of one iteration, every line of each
function automatic void expect_stream(input int iter, input int nodes, input int fv_cnt);
    fv_pkt_pkg::fv_stream_beat_t beat;
    int                          n;
    n = line_count(fv_cnt);
    for (int slot = 0; slot < nodes; slot++) begin
        for (int i = 0; i < n; i++) begin
            beat.sos  = (slot == 0) && (i == 0);
            beat.eos  = (slot == nodes - 1) && (i == n - 1);
            beat.a    = 7'(slot * 8 + i);
            beat.data = model_mem[line_addr(iter * 16 + slot, i)];
            exp_sm_q.push_back(beat);
        end
    end
endfunction

`endif

//--- tb_fv_bank.sv
// Testbench for the feature-value bank top
// Random writes, edge reads and replay streams checked against a model
`timescale 1ns/100ps

module tb_fv_bank;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    localparam int NODES        = 4;
    localparam int N_PAIRS      = 10;
    localparam int N_MIX        = 4;

    // Preload, write-then-read, two streams, held read, mixed rounds
    localparam int MAX_BEATS   = 128 + N_PAIRS * 16 + 2 * NODES * 8 + 8
                                 + N_MIX * (NODES * 8 + 24);
    localparam int WATCHDOG_NS = (MAX_BEATS * 200 + RESET_CYCLES) * CLK_PERIOD;

    logic                        clk        = 1'b0;
    logic                        reset;
    fv_pkt_pkg::fv_req_t         req;
    logic                        req_valid;
    logic                        req_ready;
    logic                        stream_begin;
    logic [1:0]                  replay_iter;
    logic [1:0]                  update_iter;
    fv_geom_pkg::fv_num_t        fv_num;
    fv_pkt_pkg::fv_stream_beat_t sm_out;
    logic                        sm_valid;
    logic                        sm_ready   = 1'b0;
    fv_pkt_pkg::fv_edge_beat_t   edge_out;
    logic                        edge_valid;
    logic                        edge_ready = 1'b0;

    integer seed;
    int     errors       = 0;
    int     test_errors  = 0;
    int     tests_run    = 0;
    int     tests_failed = 0;

    `include "tb_fv_model.svh"

    fv_bank_top #(
        .NODES_PER_ITER (NODES),
        .FIFO_DEPTH     (4)
    ) dut_i (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .stream_begin (stream_begin),
        .replay_iter  (replay_iter),
        .update_iter  (update_iter),
        .fv_num       (fv_num),
        .sm_out       (sm_out),
        .sm_valid     (sm_valid),
        .sm_ready     (sm_ready),
        .edge_out     (edge_out),
        .edge_valid   (edge_valid),
        .edge_ready   (edge_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Each ready high about 70% of cycles
    always @(posedge clk) begin
        #1;
        sm_ready   = ({$random(seed)} % 10) < 7;
        edge_ready = ({$random(seed)} % 10) < 7;
    end

    // Valid and ready are settled at the falling edge
    always @(negedge clk) begin
        if (!reset && sm_valid && sm_ready) begin
            check_sm_beat(sm_out);
        end
        if (!reset && edge_valid && edge_ready) begin
            check_edge_beat(edge_out);
        end
    end

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'({$random(seed)} % (hi - lo + 1));
    endfunction

    task automatic check_sm_beat(input fv_pkt_pkg::fv_stream_beat_t got);
        fv_pkt_pkg::fv_stream_beat_t exp;
        assert (exp_sm_q.size() != 0) else begin
            errors++;
            $display("At %0t a beat came out on sm_out while none was expected", $time);
        end
        if (exp_sm_q.size() != 0) begin
            exp = exp_sm_q.pop_front();
            assert (got === exp) else begin
                errors++;
                $display("[ERROR] %0t sm_out got %h expected %h", $time, got, exp);
            end
        end
    endtask

    task automatic check_edge_beat(input fv_pkt_pkg::fv_edge_beat_t got);
        fv_pkt_pkg::fv_edge_beat_t exp;
        assert (exp_edge_q.size() != 0) else begin
            errors++;
            $display("At %0t a beat came out on edge_out while none was expected", $time);
        end
        if (exp_edge_q.size() != 0) begin
            exp = exp_edge_q.pop_front();
            assert (got === exp) else begin
                errors++;
                $display("[ERROR] %0t edge_out got %h expected %h", $time, got, exp);
            end
        end
    endtask

    task automatic start_test();
        test_errors = errors;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d errors", tests_run, name, errors - test_errors);
        end
    endtask

    // Starts and ends 1 ns after a rising edge
    task automatic send_req(input fv_pkt_pkg::fv_req_t r);
        req       = r;
        req_valid = 1'b1;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic write_burst(input int node, input int n_lines);
        fv_pkt_pkg::fv_req_t r;
        for (int i = 0; i < n_lines; i++) begin
            r.rd_wr   = 1'b1;
            r.node_id = node[5:0];
            r.pe_tag  = 2'($random(seed));
            r.data    = $random(seed);
            r.wr_eos  = (i == n_lines - 1);
            send_req(r);
            model_mem[line_addr(node, i)] = r.data;
        end
    endtask

    task automatic issue_read(input int node, input int tag, input int fv_cnt);
        fv_pkt_pkg::fv_req_t r;
        r         = '0;
        r.node_id = node[5:0];
        r.pe_tag  = tag[1:0];
        fv_num    = fv_cnt[4:0];
        expect_read(node, tag, fv_cnt);
        send_req(r);
    endtask

    task automatic drain_queues();
        @(posedge clk);
        while (exp_sm_q.size() != 0 || exp_edge_q.size() != 0) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic pulse_stream_begin(input int fv_cnt);
        fv_num = fv_cnt[4:0];
        expect_stream(int'(replay_iter), NODES, fv_cnt);
        stream_begin = 1'b1;
        @(posedge clk);
        #1;
        stream_begin = 1'b0;
        drain_queues();
    endtask

    task automatic switch_replay_iter(input int iter, input int fv_cnt);
        fv_num = fv_cnt[4:0];
        expect_stream(iter, NODES, fv_cnt);
        replay_iter = iter[1:0];
        @(posedge clk);
        #1;
        drain_queues();
    endtask

    initial begin
        int node;
        int fv_cnt;
        int tag;
        seed         = 32'h22e7db4e;
        reset        = 1'b1;
        req          = '0;
        req_valid    = 1'b0;
        stream_begin = 1'b0;
        replay_iter  = 2'd0;
        update_iter  = 2'd1;
        fv_num       = 5'd16;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        start_test();
        @(negedge clk);
        assert (!req_ready) else begin
            errors++;
            $display("[ERROR] %0t req_ready got %b expected 0", $time, req_ready);
        end
        repeat (5) begin
            assert (!sm_valid) else begin
                errors++;
                $display("[ERROR] %0t sm_valid got %b expected 0", $time, sm_valid);
            end
            assert (!edge_valid) else begin
                errors++;
                $display("[ERROR] %0t edge_valid got %b expected 0", $time, edge_valid);
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        finish_test("idle after reset");

        // Every line of slots 0 to 3 in all iterations, so streams read known data
        for (int i = 0; i < 16; i++) begin
            write_burst((i / NODES) * 16 + i % NODES, 8);
        end

        start_test();
        for (int k = 0; k < N_PAIRS; k++) begin
            node   = rand_range(0, 63);
            fv_cnt = rand_range(1, 16);
            write_burst(node, line_count(fv_cnt));
            issue_read(node, rand_range(0, 3), fv_cnt);
            drain_queues();
        end
        finish_test("write then read");

        start_test();
        update_iter = 2'd0;
        pulse_stream_begin(rand_range(1, 16));
        finish_test("stream on stream_begin");

        start_test();
        switch_replay_iter((int'(replay_iter) + rand_range(1, 3)) % 4, rand_range(1, 16));
        finish_test("stream on replay_iter change");

        // Held read while the update iteration is even
        start_test();
        node        = rand_range(0, 3) * 16 + rand_range(0, NODES - 1);
        fv_cnt      = rand_range(1, 16);
        tag         = rand_range(0, 3);
        req         = '0;
        req.node_id = node[5:0];
        req.pe_tag  = tag[1:0];
        req_valid   = 1'b1;
        repeat (8) begin
            @(negedge clk);
            assert (!req_ready) else begin
                errors++;
                $display("[ERROR] %0t req_ready got %b expected 0", $time, req_ready);
            end
        end
        @(posedge clk);
        #1;
        update_iter = 2'd1;
        issue_read(node, tag, fv_cnt);
        drain_queues();
        finish_test("request held in even update iteration");

        start_test();
        for (int k = 0; k < N_MIX; k++) begin
            update_iter = 2'd2;
            pulse_stream_begin(rand_range(1, 16));
            update_iter = 2'd3;
            node        = rand_range(0, 63);
            fv_cnt      = rand_range(1, 16);
            write_burst(node, line_count(fv_cnt));
            issue_read(node, rand_range(0, 3), fv_cnt);
            issue_read(rand_range(0, 3) * 16 + rand_range(0, NODES - 1), rand_range(0, 3),
                       rand_range(1, 16));
            drain_queues();
        end
        finish_test("mixed traffic under random ready");

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- fv_bank_top.sv
// Feature-value bank top, decode, controller, SRAM
// and the stream and edge output FIFOs
`timescale 1ns/100ps

module fv_bank_top #(
    parameter int NODES_PER_ITER = 16,
    parameter int FIFO_DEPTH     = 4
) (
    input  logic                              clk,
    input  logic                              reset,
    input  fv_pkt_pkg::fv_req_t               req,
    input  logic                              req_valid,
    output logic                              req_ready,
    input  logic                              stream_begin,
    input  logic [fv_geom_pkg::ITER_BITS-1:0] replay_iter,
    input  logic [fv_geom_pkg::ITER_BITS-1:0] update_iter,
    input  fv_geom_pkg::fv_num_t              fv_num,
    output fv_pkt_pkg::fv_stream_beat_t       sm_out,
    output logic                              sm_valid,
    input  logic                              sm_ready,
    output fv_pkt_pkg::fv_edge_beat_t         edge_out,
    output logic                              edge_valid,
    input  logic                              edge_ready
);
    localparam int FREE_BITS = $clog2(FIFO_DEPTH + 1);

    fv_pkt_pkg::fv_cmd_t         cmd;
    logic                        cmd_valid;
    logic                        cmd_ready;
    fv_pkt_pkg::fv_sram_req_t    sram_req;
    fv_geom_pkg::line_t          rdata;
    logic                        sm_push;
    fv_pkt_pkg::fv_stream_beat_t sm_beat;
    logic [FREE_BITS-1:0]        sm_free;
    logic                        edge_push;
    fv_pkt_pkg::fv_edge_beat_t   edge_beat;
    logic [FREE_BITS-1:0]        edge_free;

    fv_req_decode #(
        .NODES_PER_ITER (NODES_PER_ITER)
    ) decode_i (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .stream_begin (stream_begin),
        .replay_iter  (replay_iter),
        .update_iter  (update_iter),
        .fv_num       (fv_num),
        .cmd          (cmd),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready)
    );

    fv_bank_cntl #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) cntl_i (
        .clk       (clk),
        .reset     (reset),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .sram_req  (sram_req),
        .rdata     (rdata),
        .sm_free   (sm_free),
        .edge_free (edge_free),
        .sm_push   (sm_push),
        .sm_beat   (sm_beat),
        .edge_push (edge_push),
        .edge_beat (edge_beat)
    );

    fv_sram_bank sram_i (
        .clk      (clk),
        .sram_req (sram_req),
        .rdata    (rdata)
    );

    fv_out_fifo #(
        .payload_t (fv_pkt_pkg::fv_stream_beat_t),
        .DEPTH     (FIFO_DEPTH)
    ) sm_fifo_i (
        .clk       (clk),
        .reset     (reset),
        .push      (sm_push),
        .push_data (sm_beat),
        .pop_valid (sm_valid),
        .pop_data  (sm_out),
        .pop_ready (sm_ready),
        .free      (sm_free)
    );

    fv_out_fifo #(
        .payload_t (fv_pkt_pkg::fv_edge_beat_t),
        .DEPTH     (FIFO_DEPTH)
    ) edge_fifo_i (
        .clk       (clk),
        .reset     (reset),
        .push      (edge_push),
        .push_data (edge_beat),
        .pop_valid (edge_valid),
        .pop_data  (edge_out),
        .pop_ready (edge_ready),
        .free      (edge_free)
    );

endmodule

//--- fv_out_fifo.sv
// Output FIFO for one beat type, with free-slot count
`timescale 1ns/100ps

module fv_out_fifo #(
    parameter  type payload_t = logic,
    parameter  int  DEPTH     = 4,
    localparam int  PTR_BITS  = $clog2(DEPTH),
    localparam int  CNT_BITS  = $clog2(DEPTH + 1)
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                push,
    input  payload_t            push_data,
    output logic                pop_valid,
    output payload_t            pop_data,
    input  logic                pop_ready,
    output logic [CNT_BITS-1:0] free
);
    payload_t            mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                pop;

    // Wraps for any depth
    function automatic logic [PTR_BITS-1:0] bump(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign pop_valid = (count != '0);
    assign pop_data  = mem[rd_ptr];
    assign pop       = pop_valid && pop_ready;
    assign free      = CNT_BITS'(DEPTH) - count;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= bump(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= bump(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        push |-> count != CNT_BITS'(DEPTH));

endmodule

//--- fv_sram_bank.sv
// Behavioural one-port bank SRAM, active-low enables
`timescale 1ns/100ps

module fv_sram_bank (
    input  logic                     clk,
    input  fv_pkt_pkg::fv_sram_req_t sram_req,
    output fv_geom_pkg::line_t       rdata
);
    fv_geom_pkg::line_t mem [2**fv_geom_pkg::ADDR_BITS];

    // Read data holds until the next read
    always_ff @(posedge clk) begin
        if (!sram_req.cen) begin
            if (!sram_req.wen) begin
                mem[sram_req.addr] <= sram_req.data;
            end else begin
                rdata <= mem[sram_req.addr];
            end
        end
    end

    a_addr_known: assert property (@(posedge clk)
        !sram_req.cen |-> !$isunknown(sram_req.addr));

endmodule

//--- fv_bank_cntl.sv
// Bank controller FSM, sequences SRAM accesses
// and tags read data as stream or edge beats
`timescale 1ns/100ps

module fv_bank_cntl #(
    parameter  int FIFO_DEPTH = 4,
    localparam int FREE_BITS  = $clog2(FIFO_DEPTH + 1)
) (
    input  logic                        clk,
    input  logic                        reset,
    input  fv_pkt_pkg::fv_cmd_t         cmd,
    input  logic                        cmd_valid,
    output logic                        cmd_ready,
    output fv_pkt_pkg::fv_sram_req_t    sram_req,
    input  fv_geom_pkg::line_t          rdata,
    input  logic [FREE_BITS-1:0]        sm_free,
    input  logic [FREE_BITS-1:0]        edge_free,
    output logic                        sm_push,
    output fv_pkt_pkg::fv_stream_beat_t sm_beat,
    output logic                        edge_push,
    output fv_pkt_pkg::fv_edge_beat_t   edge_beat
);
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_STREAM,
        ST_READ,
        ST_LAST
    } state_e;

    state_e                          state;
    fv_pkt_pkg::fv_cmd_t             cur;
    fv_geom_pkg::line_cnt_t          line_idx;
    logic [fv_geom_pkg::NODE_BITS:0] node_idx;
    fv_geom_pkg::slot_line_t         slot_line;
    logic                            first;
    logic                            issue;
    logic                            last_line;
    logic                            last_node;
    logic [FREE_BITS-1:0]            free;

    // Slot and line of the final beat of the command in flight
    fv_geom_pkg::slot_line_t         end_a;

    // Tags of the read in flight
    logic                    rd_pend;
    logic                    rd_sos;
    logic                    rd_eos;
    fv_geom_pkg::slot_line_t rd_a;

    assign slot_line = {node_idx[fv_geom_pkg::NODE_BITS-1:0],
                        line_idx[fv_geom_pkg::LINE_BITS-1:0]};
    assign last_line = (line_idx == cur.lines - 1'b1);
    assign last_node = (node_idx == cur.node_cnt - 1'b1);
    assign cmd_ready = (state == ST_IDLE);

    assign end_a = {(fv_geom_pkg::NODE_BITS)'(cur.node_cnt - 1'b1),
                    (fv_geom_pkg::LINE_BITS)'(cur.lines - 1'b1)};

    // Room must cover the beat already on its way
    assign free  = (cur.op == fv_pkt_pkg::STREAM) ? sm_free : edge_free;
    assign issue = ((state == ST_STREAM) || (state == ST_READ))
                   && (free > FREE_BITS'(rd_pend));

    always_comb begin
        sram_req.cen  = 1'b1;
        sram_req.wen  = 1'b1;
        sram_req.addr = cur.base + fv_geom_pkg::addr_t'(slot_line);
        sram_req.data = cmd.data;
        if (state == ST_IDLE && cmd_valid && cmd.op == fv_pkt_pkg::WRITE) begin
            sram_req.cen  = 1'b0;
            sram_req.wen  = 1'b0;
            sram_req.addr = cmd.base;
        end else if (issue) begin
            sram_req.cen = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_IDLE;
            line_idx <= '0;
            node_idx <= '0;
            first    <= 1'b0;
            rd_pend  <= 1'b0;
        end else begin
            rd_pend <= issue;
            case (state)
                ST_IDLE: begin
                    // Writes finish here, reads and streams start a run
                    if (cmd_valid && cmd.op != fv_pkt_pkg::WRITE) begin
                        state    <= (cmd.op == fv_pkt_pkg::STREAM) ? ST_STREAM : ST_READ;
                        line_idx <= '0;
                        node_idx <= '0;
                        first    <= 1'b1;
                    end
                end
                ST_STREAM, ST_READ: begin
                    if (issue) begin
                        first <= 1'b0;
                        if (last_line) begin
                            line_idx <= '0;
                            node_idx <= node_idx + 1'b1;
                            if (last_node) begin
                                state <= ST_LAST;
                            end
                        end else begin
                            line_idx <= line_idx + 1'b1;
                        end
                    end
                end
                default: begin
                    // Final beat is pushed in this cycle
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            cur <= cmd;
        end
        if (issue) begin
            rd_sos <= first;
            rd_eos <= last_line && last_node;
            rd_a   <= slot_line;
        end
    end

    assign sm_push        = rd_pend && (cur.op == fv_pkt_pkg::STREAM);
    assign sm_beat.sos    = rd_sos;
    assign sm_beat.eos    = rd_eos;
    assign sm_beat.a      = rd_a;
    assign sm_beat.data   = rdata;

    assign edge_push        = rd_pend && (cur.op != fv_pkt_pkg::STREAM);
    assign edge_beat.sos    = rd_sos;
    assign edge_beat.eos    = rd_eos;
    assign edge_beat.pe_tag = cur.pe_tag;
    assign edge_beat.data   = rdata;

    a_sm_room: assert property (@(posedge clk) disable iff (reset)
        sm_push |-> sm_free != '0);

    a_edge_room: assert property (@(posedge clk) disable iff (reset)
        edge_push |-> edge_free != '0);

    // sos only on slot 0 line 0, eos only on the last line of the last node
    a_beat_bounds: assert property (@(posedge clk) disable iff (reset)
        (sm_push || edge_push) |-> (rd_sos == (rd_a == '0)) && (rd_eos == (rd_a == end_a)));

endmodule

//--- fv_req_decode.sv
// Request and stream-trigger decode into bank commands
`timescale 1ns/100ps

module fv_req_decode #(
    parameter int NODES_PER_ITER = 16
) (
    input  logic                              clk,
    input  logic                              reset,
    input  fv_pkt_pkg::fv_req_t               req,
    input  logic                              req_valid,
    output logic                              req_ready,
    input  logic                              stream_begin,
    input  logic [fv_geom_pkg::ITER_BITS-1:0] replay_iter,
    input  logic [fv_geom_pkg::ITER_BITS-1:0] update_iter,
    input  fv_geom_pkg::fv_num_t              fv_num,
    output fv_pkt_pkg::fv_cmd_t               cmd,
    output logic                              cmd_valid,
    input  logic                              cmd_ready
);
    logic [fv_geom_pkg::ITER_BITS-1:0] last_iter;
    logic [fv_geom_pkg::ITER_BITS-1:0] stream_iter;
    logic                              stream_pend;
    logic [fv_geom_pkg::LINE_BITS-1:0] wr_idx;
    logic                              live;
    logic                              odd;
    logic                              trigger;
    fv_geom_pkg::fv_num_t              fv_up;

    assign odd     = update_iter[0];
    assign trigger = !odd && (stream_begin || (replay_iter != last_iter));
    assign fv_up   = fv_num + 1'b1;

    // A pending stream goes ahead of requests
    assign req_ready = live && odd && !stream_pend && cmd_ready;
    assign cmd_valid = stream_pend || (live && odd && req_valid);

    always_comb begin
        cmd.lines    = fv_up[$bits(fv_geom_pkg::fv_num_t)-1:1];
        cmd.node_cnt = 'd1;
        cmd.pe_tag   = '0;
        cmd.data     = '0;
        if (stream_pend) begin
            cmd.op       = fv_pkt_pkg::STREAM;
            cmd.base     = {stream_iter, {$bits(fv_geom_pkg::slot_line_t){1'b0}}};
            cmd.node_cnt = (fv_geom_pkg::NODE_BITS+1)'(NODES_PER_ITER);
        end else if (req.rd_wr) begin
            cmd.op    = fv_pkt_pkg::WRITE;
            cmd.base  = {req.node_id, wr_idx};
            cmd.lines = 'd1;
            cmd.data  = req.data;
        end else begin
            cmd.op     = fv_pkt_pkg::READ;
            cmd.base   = {req.node_id, {fv_geom_pkg::LINE_BITS{1'b0}}};
            cmd.pe_tag = req.pe_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            live        <= 1'b0;
            stream_pend <= 1'b0;
            last_iter   <= '0;
            wr_idx      <= '0;
        end else begin
            live <= 1'b1;
            if (stream_pend) begin
                if (cmd_ready) begin
                    stream_pend <= 1'b0;
                end
            end else if (trigger) begin
                stream_pend <= 1'b1;
                last_iter   <= replay_iter;
            end
            // Write beats fill consecutive lines of the node
            if (req_valid && req_ready && req.rd_wr) begin
                wr_idx <= req.wr_eos ? '0 : wr_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stream_pend && trigger) begin
            stream_iter <= replay_iter;
        end
    end

    a_cmd_hold: assert property (@(posedge clk) disable iff (reset)
        cmd_valid && !cmd_ready |=> !cmd_valid || $stable(cmd));

endmodule

//--- fv_pkt_pkg.sv
// Request, command, SRAM access and output beat structs
package fv_pkt_pkg;

    // Write-back or edge-read request
    typedef struct packed {
        logic                                 rd_wr;
        logic [fv_geom_pkg::NODE_ID_BITS-1:0] node_id;
        logic [fv_geom_pkg::PE_TAG_BITS-1:0]  pe_tag;
        fv_geom_pkg::line_t                   data;
        logic                                 wr_eos;
    } fv_req_t;

    typedef enum logic [1:0] {
        STREAM,
        WRITE,
        READ
    } fv_op_e;

    typedef struct packed {
        fv_op_e                              op;
        fv_geom_pkg::addr_t                  base;
        fv_geom_pkg::line_cnt_t              lines;
        logic [fv_geom_pkg::NODE_BITS:0]     node_cnt;
        logic [fv_geom_pkg::PE_TAG_BITS-1:0] pe_tag;
        fv_geom_pkg::line_t                  data;
    } fv_cmd_t;

    // Enables are active low
    typedef struct packed {
        logic               cen;
        logic               wen;
        fv_geom_pkg::addr_t addr;
        fv_geom_pkg::line_t data;
    } fv_sram_req_t;

    typedef struct packed {
        logic                    sos;
        logic                    eos;
        fv_geom_pkg::slot_line_t a;
        fv_geom_pkg::line_t      data;
    } fv_stream_beat_t;

    typedef struct packed {
        logic                                sos;
        logic                                eos;
        logic [fv_geom_pkg::PE_TAG_BITS-1:0] pe_tag;
        fv_geom_pkg::line_t                  data;
    } fv_edge_beat_t;

endpackage

//--- fv_geom_pkg.sv
// Feature-value bank geometry constants
// Address, line and count types shared across the bank
package fv_geom_pkg;

    localparam int FV_WIDTH   = 16;
    localparam int LINE_WIDTH = 2 * FV_WIDTH;
    localparam int MAX_FV_NUM = 16;

    // Address fields, high to low: iteration, node slot, line
    localparam int LINE_BITS    = 3;
    localparam int NODE_BITS    = 4;
    localparam int ITER_BITS    = 2;
    localparam int ADDR_BITS    = ITER_BITS + NODE_BITS + LINE_BITS;
    localparam int NODE_ID_BITS = ITER_BITS + NODE_BITS;

    localparam int PE_TAG_BITS = 2;

    typedef logic [LINE_WIDTH-1:0] line_t;
    typedef logic [ADDR_BITS-1:0]  addr_t;

    // Node slot and line within one iteration
    typedef logic [NODE_BITS+LINE_BITS-1:0] slot_line_t;

    // 0 to 16 feature values
    typedef logic [$clog2(MAX_FV_NUM+1)-1:0] fv_num_t;

    // 0 to 8 lines
    typedef logic [$clog2(MAX_FV_NUM/2+1)-1:0] line_cnt_t;

endpackage
